// File: rv_subsystem.f
rv_core_pkg.sv
rv_fetch.sv
rv_inst_queue.sv
rv_regfile.sv
rv_execute.sv
rv_subsystem.sv
tb_rv_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_rv_subsystem \
  -f rv_subsystem.f --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Verification passed$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: tb_rv_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_subsystem;

  localparam logic [31:0] SEED      = 32'hf4deadc9;
  localparam logic [31:0] BOOT_ADDR = 32'h0;
  localparam logic [2:0]  F3_W      = 3'b010;

  logic                 clk;
  logic                 rst_n;
  rv_core_pkg::wb_req_t imem_req;
  rv_core_pkg::wb_rsp_t imem_rsp;
  rv_core_pkg::wb_req_t dmem_req;
  rv_core_pkg::wb_rsp_t dmem_rsp;
  logic                 halted;

  // program words, data RAM and the write log
  logic [31:0]          prog [$];
  logic [31:0]          ram [0:63];
  rv_core_pkg::wb_req_t store_log [$];
  rv_core_pkg::wb_req_t expected [$];
  int                   dmem_wait_max;
  logic                 stall_seen;
  int                   errors;
  int                   timeouts;
  string                test_name;

  rv_subsystem #(
    .BOOT_ADDR   (BOOT_ADDR),
    .QUEUE_DEPTH (4)
  ) i_rv_subsystem (
    .clk      (clk),
    .rst_n    (rst_n),
    .imem_req (imem_req),
    .imem_rsp (imem_rsp),
    .dmem_req (dmem_req),
    .dmem_rsp (dmem_rsp),
    .halted   (halted)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] adr);
    return adr ^ 32'hc3c3_a5a5;
  endfunction

  // past the end of the program the core sees ecall
  function automatic logic [31:0] rom_word(input logic [31:0] adr);
    int idx;
    idx = int'(adr >> 2);
    if (idx < prog.size()) begin
      return prog[idx];
    end
    return rv_core_pkg::INSTR_ECALL;
  endfunction

  // instruction encoders
  function automatic logic [31:0] r_type(input int f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3, rd[4:0], rv_core_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                         input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic logic [31:0] s_type(input int rs1, input int rs2, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], F3_W, imm[4:0], rv_core_pkg::OPC_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input int rs1,
                                         input int rs2, input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11],
            rv_core_pkg::OPC_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input int rd, input int imm20);
    return {imm20[19:0], rd[4:0], rv_core_pkg::OPC_LUI};
  endfunction

  function automatic logic [31:0] j_type(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_core_pkg::OPC_JAL};
  endfunction

  // instruction slave, read only
  initial begin : imem_model
    logic [31:0]          state;
    int                   wait_left;
    logic                 busy;
    rv_core_pkg::wb_rsp_t rsp;
    state     = SEED;
    wait_left = 0;
    busy      = 1'b0;
    imem_rsp  = '0;
    forever begin
      @(posedge clk);
      #1;
      if (imem_rsp.ack || !(imem_req.cyc && imem_req.stb)) begin
        busy = 1'b0;
      end
      rsp = '0;
      if (imem_req.cyc && imem_req.stb) begin
        if (!busy) begin
          state     = next_random(state);
          wait_left = int'(state[1:0]);
          busy      = 1'b1;
        end
        if (wait_left == 0) begin
          rsp.ack = 1'b1;
          rsp.dat = rom_word(imem_req.adr);
        end else begin
          wait_left--;
        end
      end
      imem_rsp = rsp;
    end
  end

  // data slave, logs every completed write
  initial begin : dmem_model
    logic [31:0]          state;
    int                   wait_left;
    logic                 busy;
    rv_core_pkg::wb_rsp_t rsp;
    state     = next_random(SEED);
    wait_left = 0;
    busy      = 1'b0;
    dmem_rsp  = '0;
    forever begin
      @(posedge clk);
      #1;
      if (dmem_rsp.ack || !(dmem_req.cyc && dmem_req.stb)) begin
        busy = 1'b0;
      end
      // fetch idle behind a busy data bus means the queue is full
      if (dmem_req.cyc && !imem_req.cyc) begin
        stall_seen = 1'b1;
      end
      rsp = '0;
      if (dmem_req.cyc && dmem_req.stb) begin
        if (!busy) begin
          state     = next_random(state);
          wait_left = int'(state % (dmem_wait_max + 1));
          busy      = 1'b1;
        end
        if (wait_left == 0) begin
          rsp.ack = 1'b1;
          if (dmem_req.we) begin
            ram[dmem_req.adr[7:2]] = dmem_req.dat;
            store_log.push_back(dmem_req);
          end else begin
            rsp.dat = ram[dmem_req.adr[7:2]];
          end
        end else begin
          wait_left--;
        end
      end
      dmem_rsp = rsp;
    end
  end

  task automatic check_store(input rv_core_pkg::wb_req_t exp, input rv_core_pkg::wb_req_t got,
                             input string what);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s: got adr %h dat %h we %b, expected adr %h dat %h we %b",
               $time, what, got.adr, got.dat, got.we, exp.adr, exp.dat, exp.we);
    end
  endtask

  task automatic check_flag(input logic exp, input logic got, input string what);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s: got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic expect_store(input logic [31:0] adr, input logic [31:0] dat);
    rv_core_pkg::wb_req_t req;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = 1'b1;
    req.adr = adr;
    req.dat = dat;
    req.sel = 4'hf;
    expected.push_back(req);
  endtask

  task automatic begin_reset(input string name);
    @(posedge clk);
    #1;
    rst_n         = 1'b0;
    test_name     = name;
    dmem_wait_max = 3;
    prog.delete();
    expected.delete();
  endtask

  // buses quiet in reset, first fetch one cycle after release
  task automatic end_reset();
    repeat (16) @(posedge clk);
    #1;
    check_flag(1'b0, imem_req.cyc || imem_req.stb,
               $sformatf("%s: instruction bus idle in reset", test_name));
    check_flag(1'b0, dmem_req.cyc || dmem_req.stb,
               $sformatf("%s: data bus idle in reset", test_name));
    check_flag(1'b0, halted, $sformatf("%s: halted low in reset", test_name));
    store_log.delete();
    stall_seen = 1'b0;
    for (int i = 0; i < 64; i++) begin
      ram[i] = fill_word(i * 4);
    end
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_flag(1'b1, imem_req.cyc && imem_req.stb && !imem_req.we,
               $sformatf("%s: first fetch one cycle after reset", test_name));
    check_flag(1'b1, imem_req.adr == BOOT_ADDR,
               $sformatf("%s: first fetch at the boot address", test_name));
  endtask

  task automatic wait_halted(output logic done);
    int n;
    n = 0;
    while (!halted && n < 2000) begin
      @(posedge clk);
      #1;
      n++;
    end
    done = halted;
    if (!done) begin
      timeouts++;
      $display("%s: the core did not halt within 2000 cycles", test_name);
    end
  endtask

  task automatic compare_stores();
    int n;
    check_flag(1'b1, store_log.size() == expected.size(),
               $sformatf("%s: %0d stores logged, %0d expected", test_name,
                         store_log.size(), expected.size()));
    n = (store_log.size() < expected.size()) ? store_log.size() : expected.size();
    for (int i = 0; i < n; i++) begin
      check_store(expected[i], store_log[i], $sformatf("%s: store %0d", test_name, i));
    end
  endtask

  task automatic finish_test();
    logic done;
    wait_halted(done);
    if (done) begin
      compare_stores();
    end
  endtask

  task automatic arith_test();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res [1:11];
    a = 32'h0000_0123;
    b = 32'hffff_fff0;
    begin_reset("arith");
    emit(i_type(rv_core_pkg::OPC_OPIMM, rv_core_pkg::F3_ADD, 1, 0, 'h123));
    emit(i_type(rv_core_pkg::OPC_OPIMM, rv_core_pkg::F3_ADD, 2, 0, -16));
    emit(r_type(0, rv_core_pkg::F3_ADD, 3, 1, 2));
    emit(r_type('h20, rv_core_pkg::F3_ADD, 4, 1, 2));
    emit(r_type(0, rv_core_pkg::F3_AND, 5, 1, 2));
    emit(r_type(0, rv_core_pkg::F3_OR, 6, 1, 2));
    emit(r_type(0, rv_core_pkg::F3_XOR, 7, 1, 2));
    emit(i_type(rv_core_pkg::OPC_OPIMM, rv_core_pkg::F3_XOR, 8, 1, 'h7ff));
    emit(u_type(9, 'habcde));
    emit(i_type(rv_core_pkg::OPC_OPIMM, rv_core_pkg::F3_AND, 10, 1, 'h0f0));
    emit(i_type(rv_core_pkg::OPC_OPIMM, rv_core_pkg::F3_OR, 11, 2, 'h00f));
    res[1]  = a;
    res[2]  = b;
    res[3]  = a + b;
    res[4]  = a - b;
    res[5]  = a & b;
    res[6]  = a | b;
    res[7]  = a ^ b;
    res[8]  = a ^ 32'h0000_07ff;
    res[9]  = {20'habcde, 12'h000};
    res[10] = a & 32'h0000_00f0;
    res[11] = b | 32'h0000_000f;
    for (int r = 1; r <= 11; r++) begin
      emit(s_type(0, r, 'h3c + 4 * r));
      expect_store('h3c + 4 * r, res[r]);
    end
    emit(rv_core_pkg::INSTR_ECALL);
    end_reset();
    finish_test();
  endtask

  task automatic memory_test();
    begin_reset("memory");
    emit(i_type(rv_core_pkg::OPC_OPIMM, rv_core_pkg::F3_ADD, 1, 0, 'h5a5));
    emit(s_type(0, 1, 'h10));
    emit(i_type(rv_core_pkg::OPC_LOAD, F3_W, 2, 0, 'h10));
    emit(i_type(rv_core_pkg::OPC_OPIMM, rv_core_pkg::F3_ADD, 3, 2, 1));
    emit(s_type(0, 3, 'h14));
    // unwritten word returns the fill pattern
    emit(i_type(rv_core_pkg::OPC_LOAD, F3_W, 4, 0, 'h20));
    emit(s_type(0, 4, 'h24));
    emit(rv_core_pkg::INSTR_ECALL);
    expect_store(32'h10, 32'h5a5);
    expect_store(32'h14, 32'h5a6);
    expect_store(32'h24, fill_word(32'h20));
    end_reset();
    finish_test();
  endtask

  task automatic branch_test();
    begin_reset("branch");
    emit(i_type(rv_core_pkg::OPC_OPIMM, rv_core_pkg::F3_ADD, 1, 0, 5));
    emit(i_type(rv_core_pkg::OPC_OPIMM, rv_core_pkg::F3_ADD, 2, 0, 5));
    emit(i_type(rv_core_pkg::OPC_OPIMM, rv_core_pkg::F3_ADD, 3, 0, -3));
    emit(b_type(rv_core_pkg::F3_BEQ, 1, 2, 8));
    emit(s_type(0, 1, 'h80));
    emit(b_type(rv_core_pkg::F3_BNE, 1, 2, 8));
    emit(s_type(0, 2, 'h30));
    emit(b_type(rv_core_pkg::F3_BLT, 3, 1, 8));
    emit(s_type(0, 3, 'h84));
    emit(b_type(rv_core_pkg::F3_BLT, 1, 3, 8));
    emit(s_type(0, 3, 'h34));
    emit(b_type(rv_core_pkg::F3_BNE, 1, 3, 8));
    emit(s_type(0, 1, 'h88));
    emit(b_type(rv_core_pkg::F3_BEQ, 1, 3, 8));
    emit(s_type(0, 1, 'h38));
    emit(rv_core_pkg::INSTR_ECALL);
    // stores to 0x80..0x88 sit on wrong paths
    expect_store(32'h30, 32'd5);
    expect_store(32'h34, 32'hffff_fffd);
    expect_store(32'h38, 32'd5);
    end_reset();
    finish_test();
  endtask

  task automatic jal_test();
    begin_reset("jal");
    emit(i_type(rv_core_pkg::OPC_OPIMM, rv_core_pkg::F3_ADD, 1, 0, 7));
    emit(j_type(5, 12));
    emit(s_type(0, 1, 'h90));
    emit(s_type(0, 1, 'h94));
    emit(s_type(0, 5, 'h40));
    emit(s_type(0, 1, 'h44));
    emit(rv_core_pkg::INSTR_ECALL);
    // jal sits at pc 4, so the link is 8
    expect_store(32'h40, 32'd8);
    expect_store(32'h44, 32'd7);
    end_reset();
    finish_test();
  endtask

  task automatic halt_test();
    logic done;
    logic cyc_seen;
    logic held;
    cyc_seen = 1'b0;
    held     = 1'b1;
    begin_reset("halt");
    emit(i_type(rv_core_pkg::OPC_OPIMM, rv_core_pkg::F3_ADD, 1, 0, 'h11));
    emit(s_type(0, 1, 'h50));
    emit(rv_core_pkg::INSTR_ECALL);
    emit(s_type(0, 1, 'h54));
    emit(i_type(rv_core_pkg::OPC_OPIMM, rv_core_pkg::F3_ADD, 1, 1, 1));
    emit(s_type(0, 1, 'h58));
    expect_store(32'h50, 32'h11);
    end_reset();
    wait_halted(done);
    if (done) begin
      for (int i = 0; i < 50; i++) begin
        @(posedge clk);
        #1;
        if (dmem_req.cyc) begin
          cyc_seen = 1'b1;
        end
        if (!halted) begin
          held = 1'b0;
        end
      end
      check_flag(1'b0, cyc_seen, "halt: data bus cycle after ecall");
      check_flag(1'b1, held, "halt: halted stays high");
      compare_stores();
    end
  endtask

  task automatic backpressure_test();
    logic [31:0] acc;
    logic [31:0] mix;
    acc = 32'd0;
    mix = 32'd0;
    begin_reset("backpressure");
    dmem_wait_max = 20;
    for (int k = 0; k < 10; k++) begin
      emit(i_type(rv_core_pkg::OPC_OPIMM, rv_core_pkg::F3_ADD, 1, 1, k + 3));
      emit(r_type(0, rv_core_pkg::F3_XOR, 2, 2, 1));
      emit(s_type(0, 1, 'h60 + 8 * k));
      emit(s_type(0, 2, 'h64 + 8 * k));
      acc = acc + (k + 3);
      mix = mix ^ acc;
      expect_store('h60 + 8 * k, acc);
      expect_store('h64 + 8 * k, mix);
    end
    emit(rv_core_pkg::INSTR_ECALL);
    end_reset();
    finish_test();
    check_flag(1'b1, stall_seen, "backpressure: fetch stalls behind a full queue");
  endtask

  initial begin : main
    errors        = 0;
    timeouts      = 0;
    rst_n         = 1'b0;
    dmem_wait_max = 3;
    stall_seen    = 1'b0;
    test_name     = "init";
    arith_test();
    memory_test();
    branch_test();
    jal_test();
    halt_test();
    backpressure_test();
    $display("summary: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module rv_subsystem #(
  parameter logic [31:0] BOOT_ADDR   = 32'h0,
  parameter int          QUEUE_DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  output rv_core_pkg::wb_req_t imem_req,
  input  rv_core_pkg::wb_rsp_t imem_rsp,
  output rv_core_pkg::wb_req_t dmem_req,
  input  rv_core_pkg::wb_rsp_t dmem_rsp,
  output logic                 halted
);

  logic                     push;
  logic                     full;
  rv_core_pkg::fetch_item_t push_item;
  logic                     q_valid;
  rv_core_pkg::fetch_item_t q_item;
  logic                     pop;
  logic                     redirect;
  logic [31:0]              redirect_pc;
  logic [4:0]               rf_raddr1;
  logic [4:0]               rf_raddr2;
  logic [31:0]              rf_rdata1;
  logic [31:0]              rf_rdata2;
  logic                     rf_we;
  logic [4:0]               rf_waddr;
  logic [31:0]              rf_wdata;

  rv_fetch #(
    .BOOT_ADDR (BOOT_ADDR)
  ) i_rv_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .imem_req    (imem_req),
    .imem_rsp    (imem_rsp),
    .push        (push),
    .push_item   (push_item),
    .full        (full),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  // a taken transfer also empties the queue
  rv_inst_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_rv_inst_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_item (push_item),
    .full      (full),
    .q_valid   (q_valid),
    .q_item    (q_item),
    .pop       (pop),
    .flush     (redirect)
  );

  rv_regfile i_rv_regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr1 (rf_raddr1),
    .raddr2 (rf_raddr2),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2),
    .we     (rf_we),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata)
  );

  rv_execute i_rv_execute (
    .clk         (clk),
    .rst_n       (rst_n),
    .q_valid     (q_valid),
    .q_item      (q_item),
    .pop         (pop),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .rf_raddr1   (rf_raddr1),
    .rf_raddr2   (rf_raddr2),
    .rf_rdata1   (rf_rdata1),
    .rf_rdata2   (rf_rdata2),
    .rf_we       (rf_we),
    .rf_waddr    (rf_waddr),
    .rf_wdata    (rf_wdata),
    .dmem_req    (dmem_req),
    .dmem_rsp    (dmem_rsp),
    .halted      (halted)
  );

endmodule

`default_nettype wire

// File: rv_execute.sv
`timescale 1ns/100ps
`default_nettype none

module rv_execute (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     q_valid,
  input  rv_core_pkg::fetch_item_t q_item,
  output logic                     pop,
  output logic                     redirect,
  output logic [31:0]              redirect_pc,
  output logic [4:0]               rf_raddr1,
  output logic [4:0]               rf_raddr2,
  input  logic [31:0]              rf_rdata1,
  input  logic [31:0]              rf_rdata2,
  output logic                     rf_we,
  output logic [4:0]               rf_waddr,
  output logic [31:0]              rf_wdata,
  output rv_core_pkg::wb_req_t     dmem_req,
  input  rv_core_pkg::wb_rsp_t     dmem_rsp,
  output logic                     halted
);

  // word access only
  localparam logic [2:0] F3_W = 3'b010;

  logic [31:0] instr;
  logic [31:0] pc;
  logic [6:0]  opcode;
  logic [2:0]  f3;
  logic [4:0]  rd;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] imm_u;
  logic [31:0] opb;
  logic [31:0] alu_res;
  logic        alu_ok;
  logic        br_cond;
  logic        is_alu;
  logic        is_lui;
  logic        is_jal;
  logic        is_lw;
  logic        is_sw;
  logic        is_ecall;
  logic        can_issue;
  logic        mem_issue;
  logic        wr_en;
  logic [31:0] wr_data;
  logic        mem_ack;
  logic        load_done;
  logic        pend_q;
  logic [4:0]  pend_rd;
  logic        halted_q;

  rv_core_pkg::wb_req_t issue_req;
  rv_core_pkg::wb_req_t pend_req;

  assign instr  = q_item.instr;
  assign pc     = q_item.pc;
  assign opcode = instr[6:0];
  assign f3     = instr[14:12];
  assign rd     = instr[11:7];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_u = {instr[31:12], 12'd0};

  assign rf_raddr1 = instr[19:15];
  assign rf_raddr2 = instr[24:20];

  always_comb begin
    opb    = (opcode == rv_core_pkg::OPC_OP) ? rf_rdata2 : imm_i;
    alu_ok = 1'b1;
    case (f3)
      rv_core_pkg::F3_ADD: begin
        // sub only for register form with funct7 bit 5
        if (opcode == rv_core_pkg::OPC_OP && instr[30]) begin
          alu_res = rf_rdata1 - opb;
        end else begin
          alu_res = rf_rdata1 + opb;
        end
      end
      rv_core_pkg::F3_XOR: alu_res = rf_rdata1 ^ opb;
      rv_core_pkg::F3_OR:  alu_res = rf_rdata1 | opb;
      rv_core_pkg::F3_AND: alu_res = rf_rdata1 & opb;
      default: begin
        alu_res = 32'd0;
        alu_ok  = 1'b0;
      end
    endcase
  end

  always_comb begin
    case (f3)
      rv_core_pkg::F3_BEQ: br_cond = (rf_rdata1 == rf_rdata2);
      rv_core_pkg::F3_BNE: br_cond = (rf_rdata1 != rf_rdata2);
      rv_core_pkg::F3_BLT: br_cond = ($signed(rf_rdata1) < $signed(rf_rdata2));
      default:             br_cond = 1'b0;
    endcase
  end

  assign is_alu   = alu_ok && (opcode == rv_core_pkg::OPC_OP ||
                               opcode == rv_core_pkg::OPC_OPIMM);
  assign is_lui   = (opcode == rv_core_pkg::OPC_LUI);
  assign is_jal   = (opcode == rv_core_pkg::OPC_JAL);
  assign is_lw    = (opcode == rv_core_pkg::OPC_LOAD) && (f3 == F3_W);
  assign is_sw    = (opcode == rv_core_pkg::OPC_STORE) && (f3 == F3_W);
  assign is_ecall = (instr == rv_core_pkg::INSTR_ECALL);

  // one instruction at a time, nothing after ecall
  assign can_issue = q_valid && !pend_q && !halted_q;
  assign pop       = can_issue;
  assign mem_issue = can_issue && (is_lw || is_sw);

  assign redirect    = can_issue && (is_jal || (opcode == rv_core_pkg::OPC_BRANCH && br_cond));
  assign redirect_pc = is_jal ? pc + imm_j : pc + imm_b;

  assign wr_en = is_alu || is_lui || is_jal;

  always_comb begin
    if (is_lui) begin
      wr_data = imm_u;
    end else if (is_jal) begin
      wr_data = pc + 32'd4;
    end else begin
      wr_data = alu_res;
    end
  end

  always_comb begin
    issue_req.cyc = mem_issue;
    issue_req.stb = mem_issue;
    issue_req.we  = is_sw;
    issue_req.adr = rf_rdata1 + (is_sw ? imm_s : imm_i);
    issue_req.dat = rf_rdata2;
    issue_req.sel = 4'hf;
  end

  // held copy drives the bus until ack
  assign dmem_req  = pend_q ? pend_req : issue_req;
  assign mem_ack   = dmem_req.cyc && dmem_rsp.ack;
  assign load_done = mem_ack && !dmem_req.we;

  assign rf_we    = (can_issue && wr_en) || load_done;
  assign rf_waddr = (load_done && pend_q) ? pend_rd : rd;
  assign rf_wdata = load_done ? dmem_rsp.dat : wr_data;

  assign halted = halted_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q   <= 1'b0;
      halted_q <= 1'b0;
    end else begin
      if (mem_issue && !mem_ack) begin
        pend_q <= 1'b1;
      end else if (mem_ack) begin
        pend_q <= 1'b0;
      end
      if (can_issue && is_ecall) begin
        halted_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_issue) begin
      pend_req <= issue_req;
      pend_rd  <= rd;
    end
  end

endmodule

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  raddr1,
  input  logic [4:0]  raddr2,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2,
  input  logic        we,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata
);

  // x1..x31, x0 has no storage
  logic [31:0] regs [1:31];

  assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (we && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

`default_nettype wire

// File: rv_inst_queue.sv
`timescale 1ns/100ps
`default_nettype none

module rv_inst_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     push,
  input  rv_core_pkg::fetch_item_t push_item,
  output logic                     full,
  output logic                     q_valid,
  output rv_core_pkg::fetch_item_t q_item,
  input  logic                     pop,
  input  logic                     flush
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  rv_core_pkg::fetch_item_t mem [QUEUE_DEPTH];

  // extra msb tells full from empty
  logic [PTR_W:0] wr_ptr;
  logic [PTR_W:0] rd_ptr;
  logic           do_push;
  logic           do_pop;

  assign full    = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
  assign q_valid = (wr_ptr != rd_ptr);
  assign q_item  = mem[rd_ptr[PTR_W-1:0]];

  // flush wins over a push in the same cycle
  assign do_push = push && !full && !flush;
  assign do_pop  = pop && q_valid && !flush;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[PTR_W-1:0]] <= push_item;
    end
  end

endmodule

`default_nettype wire

// File: rv_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module rv_fetch #(
  parameter logic [31:0] BOOT_ADDR = 32'h0
) (
  input  logic                     clk,
  input  logic                     rst_n,
  output rv_core_pkg::wb_req_t     imem_req,
  input  rv_core_pkg::wb_rsp_t     imem_rsp,
  output logic                     push,
  output rv_core_pkg::fetch_item_t push_item,
  input  logic                     full,
  input  logic                     redirect,
  input  logic [31:0]              redirect_pc
);

  logic        run_q;
  logic        active_q;
  logic        discard_q;
  logic [31:0] pc_q;
  logic [31:0] adr_q;
  logic        launch;
  logic        req;
  logic        ack;
  logic [31:0] cur_adr;

  // a new cycle only starts while the queue has room
  assign launch  = run_q && !active_q && !full;
  assign req     = active_q || launch;
  assign ack     = req && imem_rsp.ack;
  assign cur_adr = active_q ? adr_q : pc_q;

  always_comb begin
    imem_req.cyc = req;
    imem_req.stb = req;
    imem_req.we  = 1'b0;
    imem_req.adr = cur_adr;
    imem_req.dat = '0;
    imem_req.sel = 4'hf;
  end

  // wrong-path words are completed on the bus but never queued
  assign push = ack && !discard_q && !redirect;

  always_comb begin
    push_item.pc    = cur_adr;
    push_item.instr = imem_rsp.dat;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q     <= 1'b0;
      active_q  <= 1'b0;
      discard_q <= 1'b0;
      pc_q      <= BOOT_ADDR;
    end else begin
      run_q <= 1'b1;
      if (ack) begin
        active_q  <= 1'b0;
        discard_q <= 1'b0;
      end else if (req) begin
        active_q <= 1'b1;
        // redirect during an open read
        if (redirect) begin
          discard_q <= 1'b1;
        end
      end
      if (redirect) begin
        pc_q <= redirect_pc;
      end else if (launch) begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  // address held stable for the open cycle
  always_ff @(posedge clk) begin
    if (launch) begin
      adr_q <= pc_q;
    end
  end

endmodule

`default_nettype wire

// File: rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  // wishbone classic master request
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_req_t;

  // slave response
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // one fetched instruction with its address
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
  } fetch_item_t;

  // major opcodes of the supported subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // funct3 codes
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;

  localparam logic [31:0] INSTR_ECALL = 32'h0000_0073;

endpackage

`default_nettype wire
